// File: build.f
+incdir+tb
rtl/pipe_cfg_pkg.sv
rtl/isa_pkg.sv
rtl/dispatch_bundle_if.sv
rtl/decode_stage.sv
rtl/dispatch_buffer.sv
rtl/dispatch_gate.sv
rtl/frontend_top.sv
tb/tb_frontend.sv

// File: run.sh
#!/bin/sh
# Build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_frontend -f build.f
output=$(./obj_dir/Vtb_frontend || true)
echo "$output"
if echo "$output" | grep -qF 'All tests passed!'; then
  exit 0
fi
exit 1

// File: tb/frontend_tests.svh
//////////////////////////////
// Directed front end tests
//////////////////////////////

`ifndef FRONTEND_TESTS_SVH
`define FRONTEND_TESTS_SVH

// Word of one class with random fields, plus its destination
task automatic make_inst(input inst_class_e cls, output logic [INST_W-1:0] word,
                         output logic [REG_IDX_W-1:0] dest);
  logic [25:0] r;
  r = 26'($urandom);
  case (cls)
    CLS_ALU:       word = {OP_INTA, r};
    CLS_LOAD:      word = {OP_LDQ, r};
    CLS_STORE:     word = {OP_STQ, r};
    CLS_COND_BR:   word = {OP_BEQ, r};
    CLS_UNCOND_BR: word = {OP_BR, r};
    CLS_HALT:      word = HALT_INST;
    default:       word = {6'h3f, r};  // No such opcode
  endcase
  if (cls == CLS_ALU)
    dest = r[4:0];                      // rc field
  else if (cls == CLS_LOAD || cls == CLS_UNCOND_BR)
    dest = r[25:21];                    // ra field
  else
    dest = ZERO_REG;
endtask

task automatic drive_fetch(input logic [INST_W-1:0] ir0, input logic [INST_W-1:0] ir1,
                           input logic [WAYS-1:0] valid);
  fetch_npc[0] = next_npc + 64'd4;
  fetch_npc[1] = next_npc + 64'd8;
  fetch_ir[0]  = ir0;
  fetch_ir[1]  = ir1;
  fetch_valid  = valid;
endtask

// Offer a full bundle until fetch_ready lets it in
task automatic send_bundle(input logic [INST_W-1:0] ir0, input logic [INST_W-1:0] ir1);
  drive_fetch(ir0, ir1, 2'b11);
  sample_point();
  while (!fetch_ready)
    sample_point();
  step_cycle();  // Captured at this edge
  fetch_valid = '0;
  next_npc    = next_npc + 64'd8;
endtask

task automatic expect_flow(input logic [WAYS-1:0] valid, input logic [WAYS-1:0] fire,
                           input logic ready);
  check_value("dp_valid", 64'(dp_valid), 64'(valid));
  check_value("dp_fire", 64'(dp_fire), 64'(fire));
  check_value("fetch_ready", 64'(fetch_ready), 64'(ready));
endtask

task automatic expect_slot(input int slot, input logic [INST_W-1:0] ir,
                           input logic [REG_IDX_W-1:0] dest, input inst_class_e cls);
  check_value("dp_ir", 64'(dp_ir[slot]), 64'(ir));
  check_value("dp_dest_idx", 64'(dp_dest_idx[slot]), 64'(dest));
  check_value("dp_cls", 64'(dp_cls[slot]), 64'(cls));
endtask

//////////////////////////////
// Tests
//////////////////////////////

// Random bundles, both slots fire two cycles after capture
task automatic classify_and_flow();
  inst_class_e          cls  [WAYS];
  logic [INST_W-1:0]    word [WAYS];
  logic [REG_IDX_W-1:0] dest [WAYS];
  logic [XLEN-1:0]      base;
  reset_dut();
  for (int n = 0; n < 6; n++)
  begin
    for (int s = 0; s < WAYS; s++)
    begin
      case ($urandom_range(3))
        0:       cls[s] = CLS_ALU;
        1:       cls[s] = CLS_LOAD;
        2:       cls[s] = CLS_COND_BR;
        default: cls[s] = CLS_UNCOND_BR;
      endcase
      make_inst(cls[s], word[s], dest[s]);
    end
    base = next_npc;
    send_bundle(word[0], word[1]);
    step_cycle();
    sample_point();
    expect_flow(2'b11, 2'b11, 1'b1);
    for (int s = 0; s < WAYS; s++)
    begin
      expect_slot(s, word[s], dest[s], cls[s]);
      check_value("dp_npc", dp_npc[s], base + 64'(4 * (s + 1)));
    end
    step_cycle();
  end
endtask

// One ROB entry, so slot 2 moves up and fires a cycle later
task automatic compact_slot2();
  logic [INST_W-1:0]    word [WAYS];
  logic [REG_IDX_W-1:0] dest [WAYS];
  reset_dut();
  set_free_counts(1, 3, 3);
  make_inst(CLS_ALU, word[0], dest[0]);
  make_inst(CLS_ALU, word[1], dest[1]);
  send_bundle(word[0], word[1]);
  step_cycle();
  sample_point();
  expect_flow(2'b11, 2'b01, 1'b0);  // Partial fire
  step_cycle();
  sample_point();
  expect_flow(2'b01, 2'b01, 1'b1);
  expect_slot(0, word[1], dest[1], CLS_ALU);
  step_cycle();
endtask

// No LSQ room, the load waits behind the ALU op
task automatic lsq_stall();
  logic [INST_W-1:0]    word [WAYS];
  logic [REG_IDX_W-1:0] dest [WAYS];
  reset_dut();
  set_free_counts(3, 3, 0);
  make_inst(CLS_ALU, word[0], dest[0]);
  make_inst(CLS_LOAD, word[1], dest[1]);
  send_bundle(word[0], word[1]);
  step_cycle();
  sample_point();
  expect_flow(2'b11, 2'b01, 1'b0);
  repeat (2)
  begin
    step_cycle();
    sample_point();
    expect_flow(2'b01, 2'b00, 1'b0);
    expect_slot(0, word[1], dest[1], CLS_LOAD);
  end
  step_cycle();
  set_free_counts(3, 3, 1);
  sample_point();
  expect_flow(2'b01, 2'b01, 1'b1);
  step_cycle();
  sample_point();
  expect_flow(2'b00, 2'b00, 1'b1);
  step_cycle();
endtask

// Both stages full and stalled, then squashed
task automatic flush_both();
  logic [INST_W-1:0]    word [WAYS];
  logic [REG_IDX_W-1:0] dest [WAYS];
  reset_dut();
  set_free_counts(0, 3, 3);
  make_inst(CLS_ALU, word[0], dest[0]);
  make_inst(CLS_ALU, word[1], dest[1]);
  send_bundle(word[0], word[1]);
  drive_fetch(word[1], word[0], 2'b11);  // Second bundle right behind
  sample_point();
  expect_flow(2'b00, 2'b00, 1'b1);
  step_cycle();
  fetch_valid = '0;
  sample_point();
  expect_flow(2'b11, 2'b00, 1'b0);
  expect_slot(0, word[0], dest[0], CLS_ALU);
  step_cycle();
  flush = 1'b1;
  step_cycle();
  flush = 1'b0;
  set_free_counts(3, 3, 3);
  sample_point();
  expect_flow(2'b00, 2'b00, 1'b1);
  step_cycle();
  sample_point();
  expect_flow(2'b00, 2'b00, 1'b1);  // IF/ID was emptied too
  step_cycle();
endtask

task automatic halt_stops();
  logic [INST_W-1:0]    word [WAYS];
  logic [REG_IDX_W-1:0] dest [WAYS];
  reset_dut();
  make_inst(CLS_HALT, word[0], dest[0]);
  make_inst(CLS_ALU, word[1], dest[1]);
  send_bundle(word[0], word[1]);
  step_cycle();
  sample_point();
  expect_flow(2'b11, 2'b01, 1'b0);  // Halt goes alone
  check_value("error_status", 64'(error_status), 64'(NO_ERROR));
  repeat (3)
  begin
    step_cycle();
    sample_point();
    expect_flow(2'b01, 2'b00, 1'b0);
    check_value("error_status", 64'(error_status), 64'(HALTED_ON_HALT));
  end
endtask

task automatic illegal_stops();
  logic [INST_W-1:0]    word [WAYS];
  logic [REG_IDX_W-1:0] dest [WAYS];
  reset_dut();
  make_inst(CLS_ILLEGAL, word[0], dest[0]);
  make_inst(CLS_ALU, word[1], dest[1]);
  send_bundle(word[0], word[1]);
  step_cycle();
  sample_point();
  expect_flow(2'b11, 2'b00, 1'b0);
  expect_slot(0, word[0], dest[0], CLS_ILLEGAL);
  check_value("error_status", 64'(error_status), 64'(NO_ERROR));
  repeat (3)
  begin
    step_cycle();
    sample_point();
    expect_flow(2'b11, 2'b00, 1'b0);
    check_value("error_status", 64'(error_status), 64'(HALTED_ON_ILLEGAL));
  end
endtask

`endif

// File: tb/tb_frontend.sv
//////////////////////////////
// Front end testbench
//////////////////////////////

module tb_frontend
  import pipe_cfg_pkg::*, isa_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int FREE_W    = 2;
  localparam int NUM_TESTS = 6;
  localparam int CLK_HALF  = 10;  // 20 ns period

  logic                 clock;
  logic                 arst_n;
  logic                 flush;
  logic [XLEN-1:0]      fetch_npc   [WAYS];
  logic [INST_W-1:0]    fetch_ir    [WAYS];
  logic [WAYS-1:0]      fetch_valid;
  logic [FREE_W-1:0]    rob_free;
  logic [FREE_W-1:0]    rs_free;
  logic [FREE_W-1:0]    lsq_free;
  logic                 fetch_ready;
  logic [WAYS-1:0]      dp_valid;
  logic [WAYS-1:0]      dp_fire;
  logic [XLEN-1:0]      dp_npc      [WAYS];
  logic [INST_W-1:0]    dp_ir       [WAYS];
  logic [REG_IDX_W-1:0] dp_dest_idx [WAYS];
  inst_class_e          dp_cls      [WAYS];
  err_status_e          error_status;
  logic [XLEN-1:0]      next_npc;     // Base address of the next bundle

  frontend_top #(
    .FREE_W (FREE_W)
  ) u_frontend_top (
    .clock        (clock),
    .arst_n       (arst_n),
    .flush        (flush),
    .fetch_npc    (fetch_npc),
    .fetch_ir     (fetch_ir),
    .fetch_valid  (fetch_valid),
    .rob_free     (rob_free),
    .rs_free      (rs_free),
    .lsq_free     (lsq_free),
    .fetch_ready  (fetch_ready),
    .dp_valid     (dp_valid),
    .dp_fire      (dp_fire),
    .dp_npc       (dp_npc),
    .dp_ir        (dp_ir),
    .dp_dest_idx  (dp_dest_idx),
    .dp_cls       (dp_cls),
    .error_status (error_status)
  );

  initial
  begin
    clock = 1'b0;
    forever #CLK_HALF clock = ~clock;
  end

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  //////////////////////////////
  // Timing helpers
  //////////////////////////////

  // Drive point, just after the rising edge
  task automatic step_cycle();
    @(posedge clock);
    #2;
  endtask

  task automatic sample_point();
    @(negedge clock);  // Outputs settled
  endtask

  task automatic set_free_counts(input int rob, input int rs, input int lsq);
    rob_free = FREE_W'(rob);
    rs_free  = FREE_W'(rs);
    lsq_free = FREE_W'(lsq);
  endtask

  task automatic reset_dut();
    arst_n      = 1'b0;
    flush       = 1'b0;
    fetch_valid = '0;
    set_free_counts(3, 3, 3);
    repeat (4) @(posedge clock);
    #2;
    arst_n = 1'b1;
    sample_point();
    check_value("reset dp_valid", 64'(dp_valid), 64'(0));
    check_value("reset dp_fire", 64'(dp_fire), 64'(0));
    check_value("reset error_status", 64'(error_status), 64'(NO_ERROR));
    check_value("reset fetch_ready", 64'(fetch_ready), 64'(1));  // Empty buffer
    step_cycle();
  endtask

  `include "frontend_tests.svh"

  // Watchdog sized from the test count
  initial
  begin
    repeat (NUM_TESTS * 200) @(posedge clock);
    $display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * 200);
    $display("Test failures found");
    $fatal(1, "Watchdog expired");
  end

  initial
  begin
    arst_n      = 1'b0;
    flush       = 1'b0;
    fetch_npc   = '{default: '0};
    fetch_ir    = '{default: '0};
    fetch_valid = '0;
    rob_free    = '0;
    rs_free     = '0;
    lsq_free    = '0;
    next_npc    = 64'h1000;
    void'($urandom(32'h7a6b));
    classify_and_flow();
    compact_slot2();
    lsq_stall();
    flush_both();
    halt_stops();
    illegal_stops();
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: rtl/frontend_top.sv
//////////////////////////////
// Two-wide front end top
//////////////////////////////

module frontend_top
  import pipe_cfg_pkg::*, isa_pkg::*;
#(
  parameter int FREE_W = 2  // Width of the free-entry counts
)
(
  input  logic                 clock,
  input  logic                 arst_n,
  input  logic                 flush,        // Mispredict
  input  logic [XLEN-1:0]      fetch_npc   [WAYS],
  input  logic [INST_W-1:0]    fetch_ir    [WAYS],
  input  logic [WAYS-1:0]      fetch_valid,
  input  logic [FREE_W-1:0]    rob_free,
  input  logic [FREE_W-1:0]    rs_free,
  input  logic [FREE_W-1:0]    lsq_free,
  output logic                 fetch_ready,
  output logic [WAYS-1:0]      dp_valid,
  output logic [WAYS-1:0]      dp_fire,
  output logic [XLEN-1:0]      dp_npc      [WAYS],
  output logic [INST_W-1:0]    dp_ir       [WAYS],
  output logic [REG_IDX_W-1:0] dp_dest_idx [WAYS],
  output inst_class_e          dp_cls      [WAYS],
  output err_status_e          error_status
);

  dispatch_bundle_if id_bundle ();

  decode_stage u_decode_stage (
    .clock       (clock),
    .arst_n      (arst_n),
    .flush       (flush),
    .accept      (fetch_ready),
    .fetch_npc   (fetch_npc),
    .fetch_ir    (fetch_ir),
    .fetch_valid (fetch_valid),
    .bundle      (id_bundle.producer)
  );

  dispatch_buffer u_dispatch_buffer (
    .clock       (clock),
    .arst_n      (arst_n),
    .flush       (flush),
    .bundle      (id_bundle.consumer),
    .fire        (dp_fire),
    .accept      (fetch_ready),
    .slot_valid  (dp_valid),
    .slot_cls    (dp_cls),
    .dp_npc      (dp_npc),
    .dp_ir       (dp_ir),
    .dp_dest_idx (dp_dest_idx)
  );

  dispatch_gate #(
    .FREE_W (FREE_W)
  ) u_dispatch_gate (
    .clock        (clock),
    .arst_n       (arst_n),
    .slot_valid   (dp_valid),
    .slot_cls     (dp_cls),
    .rob_free     (rob_free),
    .rs_free      (rs_free),
    .lsq_free     (lsq_free),
    .fire         (dp_fire),
    .error_status (error_status)
  );

endmodule

// File: rtl/dispatch_gate.sv
//////////////////////////////
// Structural hazard grant
//////////////////////////////

module dispatch_gate
  import pipe_cfg_pkg::*, isa_pkg::*;
#(
  parameter int FREE_W = 2
)
(
  input  logic              clock,
  input  logic              arst_n,
  input  logic [WAYS-1:0]   slot_valid,
  input  inst_class_e       slot_cls [WAYS],
  input  logic [FREE_W-1:0] rob_free,
  input  logic [FREE_W-1:0] rs_free,
  input  logic [FREE_W-1:0] lsq_free,
  output logic [WAYS-1:0]   fire,
  output err_status_e       error_status
);

  // Room for a pair need of 2 even with narrow counts
  localparam int CMP_W = (FREE_W > 2) ? FREE_W : 2;

  logic            live;
  logic [WAYS-1:0] legal;
  logic [WAYS-1:0] rs_use;
  logic [WAYS-1:0] lsq_use;
  logic [1:0]      rs_pair;
  logic [1:0]      lsq_pair;

  function automatic logic covers(input logic [FREE_W-1:0] free, input logic [1:0] need);
    return CMP_W'(free) >= CMP_W'(need);
  endfunction

  always_comb
  begin
    for (int i = 0; i < WAYS; i++)
    begin
      legal[i]   = slot_valid[i] && (slot_cls[i] != CLS_ILLEGAL);
      rs_use[i]  = needs_rs(slot_cls[i]);
      lsq_use[i] = needs_lsq(slot_cls[i]);
    end
  end

  assign live     = (error_status == NO_ERROR);
  assign rs_pair  = {1'b0, rs_use[0]} + {1'b0, rs_use[1]};
  assign lsq_pair = {1'b0, lsq_use[0]} + {1'b0, lsq_use[1]};

  // Slot 1 alone
  assign fire[0] = live && legal[0] && covers(rob_free, 2'd1)
                && covers(rs_free, {1'b0, rs_use[0]}) && covers(lsq_free, {1'b0, lsq_use[0]});

  // Both slots on the pair's needs, never past a halt
  assign fire[1] = live && legal[0] && legal[1] && (slot_cls[0] != CLS_HALT)
                && covers(rob_free, 2'd2) && covers(rs_free, rs_pair)
                && covers(lsq_free, lsq_pair);

  //////////////////////////////
  // Error status, sticky
  //////////////////////////////

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
      error_status <= NO_ERROR;
    else if (live)
    begin
      if ((fire[0] && slot_cls[0] == CLS_HALT) || (fire[1] && slot_cls[1] == CLS_HALT))
        error_status <= HALTED_ON_HALT;
      else if (slot_valid[0] && slot_cls[0] == CLS_ILLEGAL)
        error_status <= HALTED_ON_ILLEGAL;
    end
  end

  // Pair needs always cover slot 1's own needs
  a_fire_order: assert property (
    @(posedge clock) disable iff (!arst_n)
    fire[1] |-> fire[0]
  ) else $error("slot 2 fired without slot 1");

endmodule

// File: rtl/dispatch_buffer.sv
//////////////////////////////
// ID/DP register
//////////////////////////////

module dispatch_buffer
  import pipe_cfg_pkg::*, isa_pkg::*;
(
  input  logic                 clock,
  input  logic                 arst_n,
  input  logic                 flush,
  dispatch_bundle_if.consumer  bundle,
  input  logic [WAYS-1:0]      fire,
  output logic                 accept,
  output logic [WAYS-1:0]      slot_valid,
  output inst_class_e          slot_cls    [WAYS],
  output logic [XLEN-1:0]      dp_npc      [WAYS],
  output logic [INST_W-1:0]    dp_ir       [WAYS],
  output logic [REG_IDX_W-1:0] dp_dest_idx [WAYS]
);

  logic [WAYS-1:0]      id_dp_valid;
  logic [XLEN-1:0]      id_dp_npc  [WAYS];
  logic [INST_W-1:0]    id_dp_ir   [WAYS];
  inst_class_e          id_dp_cls  [WAYS];
  logic [REG_IDX_W-1:0] id_dp_dest [WAYS];
  logic                 shift_up;

  // Every valid slot leaves, empty buffer included
  assign accept   = &(fire | ~id_dp_valid);
  assign shift_up = fire[0] && !accept;  // Slot 2 stuck behind slot 1

  //////////////////////////////
  // Payload
  //////////////////////////////

  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      id_dp_npc  <= bundle.npc;
      id_dp_ir   <= bundle.ir;
      id_dp_cls  <= bundle.cls;
      id_dp_dest <= bundle.dest_idx;
    end
    else if (shift_up)
    begin
      // Slot 2 becomes the oldest
      id_dp_npc[0]  <= id_dp_npc[1];
      id_dp_ir[0]   <= id_dp_ir[1];
      id_dp_cls[0]  <= id_dp_cls[1];
      id_dp_dest[0] <= id_dp_dest[1];
    end
  end

  //////////////////////////////
  // Valid bits
  //////////////////////////////

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
      id_dp_valid <= '0;
    else if (flush)
      id_dp_valid <= '0;
    else if (accept)
      id_dp_valid <= bundle.valid;
    else if (shift_up)
      id_dp_valid <= {1'b0, id_dp_valid[1]};
  end

  assign slot_valid  = id_dp_valid;
  assign slot_cls    = id_dp_cls;
  assign dp_npc      = id_dp_npc;
  assign dp_ir       = id_dp_ir;
  assign dp_dest_idx = id_dp_dest;

  // Program order holds across fetch, decode and compaction
  a_slot_order: assert property (
    @(posedge clock) disable iff (!arst_n)
    !(id_dp_valid[1] && !id_dp_valid[0])
  ) else $error("slot 2 valid behind an empty slot 1");

endmodule

// File: rtl/decode_stage.sv
//////////////////////////////
// IF/ID register and decode
//////////////////////////////

module decode_stage
  import pipe_cfg_pkg::*, isa_pkg::*;
(
  input  logic                clock,
  input  logic                arst_n,
  input  logic                flush,
  input  logic                accept,      // Dispatch took the whole bundle
  input  logic [XLEN-1:0]     fetch_npc [WAYS],
  input  logic [INST_W-1:0]   fetch_ir  [WAYS],
  input  logic [WAYS-1:0]     fetch_valid,
  dispatch_bundle_if.producer bundle
);

  logic [XLEN-1:0]      if_id_npc [WAYS];
  logic [INST_W-1:0]    if_id_ir  [WAYS];
  logic [WAYS-1:0]      if_id_valid;
  inst_class_e          slot_cls  [WAYS];
  logic [REG_IDX_W-1:0] slot_dest [WAYS];

  //////////////////////////////
  // IF/ID pipeline register
  //////////////////////////////

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      if_id_npc   <= '{default: '0};
      if_id_ir    <= '{default: NOOP_INST};
      if_id_valid <= '0;
    end
    else if (flush)                    // Mispredict squashes the bundle
    begin
      if_id_npc   <= '{default: '0};
      if_id_ir    <= '{default: NOOP_INST};
      if_id_valid <= '0;
    end
    else if (accept)
    begin
      if_id_npc   <= fetch_npc;
      if_id_ir    <= fetch_ir;
      if_id_valid <= fetch_valid;
    end
  end

  // Classify each slot on the major opcode
  always_comb
  begin
    for (int i = 0; i < WAYS; i++)
    begin
      slot_cls[i]  = CLS_ILLEGAL;
      slot_dest[i] = ZERO_REG;
      case (if_id_ir[i][31:26])
        OP_INTA: begin slot_cls[i] = CLS_ALU;       slot_dest[i] = if_id_ir[i][4:0];   end
        OP_LDQ:  begin slot_cls[i] = CLS_LOAD;      slot_dest[i] = if_id_ir[i][25:21]; end
        OP_STQ:  slot_cls[i] = CLS_STORE;
        OP_BEQ:  slot_cls[i] = CLS_COND_BR;
        OP_BR:   begin slot_cls[i] = CLS_UNCOND_BR; slot_dest[i] = if_id_ir[i][25:21]; end
        OP_PAL:
        begin
          if (if_id_ir[i] == HALT_INST)    // Other PAL calls unsupported
            slot_cls[i] = CLS_HALT;
        end
        default: slot_cls[i] = CLS_ILLEGAL;
      endcase
    end
  end

  assign bundle.npc      = if_id_npc;
  assign bundle.ir       = if_id_ir;
  assign bundle.valid    = if_id_valid;
  assign bundle.cls      = slot_cls;
  assign bundle.dest_idx = slot_dest;

endmodule

// File: rtl/dispatch_bundle_if.sv
//////////////////////////////
// Decoded two-slot bundle
//////////////////////////////

interface dispatch_bundle_if
  import pipe_cfg_pkg::*, isa_pkg::*;
();

  // Index 0 is slot 1, index 1 is slot 2
  logic [XLEN-1:0]      npc      [WAYS];
  logic [INST_W-1:0]    ir       [WAYS];
  logic [WAYS-1:0]      valid;
  inst_class_e          cls      [WAYS];
  logic [REG_IDX_W-1:0] dest_idx [WAYS];

  // Decode side
  modport producer (
    output npc,
    output ir,
    output valid,
    output cls,
    output dest_idx
  );

  // Dispatch side
  modport consumer (
    input npc,
    input ir,
    input valid,
    input cls,
    input dest_idx
  );

endinterface

// File: rtl/isa_pkg.sv
//////////////////////////////
// Opcodes, classes and status
//////////////////////////////

package isa_pkg;

  // Major opcode field, ir[31:26]
  typedef enum logic [5:0] {
    OP_PAL  = 6'h00,
    OP_INTA = 6'h10,
    OP_LDQ  = 6'h29,
    OP_STQ  = 6'h2d,
    OP_BR   = 6'h30,
    OP_BEQ  = 6'h39
  } opcode_e;

  // What decode makes of a word
  typedef enum logic [2:0] {
    CLS_ALU,
    CLS_LOAD,
    CLS_STORE,
    CLS_COND_BR,
    CLS_UNCOND_BR,
    CLS_HALT,
    CLS_ILLEGAL
  } inst_class_e;

  // Sticky machine status
  typedef enum logic [1:0] {
    NO_ERROR,
    HALTED_ON_HALT,
    HALTED_ON_ILLEGAL
  } err_status_e;

  //////////////////////////////
  // Resource needs per class
  //////////////////////////////

  // Memory ops take a load/store queue slot
  function automatic logic needs_lsq(input inst_class_e cls);
    return (cls == CLS_LOAD) || (cls == CLS_STORE);
  endfunction

  // Halt only goes to the ROB
  function automatic logic needs_rs(input inst_class_e cls);
    return cls != CLS_HALT;
  endfunction

endpackage

// File: rtl/pipe_cfg_pkg.sv
//////////////////////////////
// Front end datapath config
//////////////////////////////

package pipe_cfg_pkg;

  // Datapath widths
  localparam int XLEN      = 64;  // Address and NPC
  localparam int INST_W    = 32;  // Instruction word
  localparam int REG_IDX_W = 5;   // Architectural register index

  // Slots per bundle, fixed
  localparam int WAYS = 2;

  //////////////////////////////
  // Fixed instruction constants
  //////////////////////////////

  // Hardwired zero register
  localparam logic [REG_IDX_W-1:0] ZERO_REG = 5'd31;

  // ADDQ r31,r31,r31 on the integer arithmetic opcode
  localparam logic [INST_W-1:0] NOOP_INST = 32'h43ff_041f;

  // PAL call that stops the machine
  localparam logic [INST_W-1:0] HALT_INST = 32'h0000_0555;

endpackage
